//--- Bender.yml
package:
  name: segre_core

sources:
  - rtl/segre_pkg.sv
  - rtl/segre_decode.sv
  - rtl/segre_register_file.sv
  - rtl/segre_alu.sv
  - rtl/segre_ex_stage.sv
  - rtl/segre_core.sv
  - target: simulation
    files:
      - tb/segre_core_props.sv
      - tb/tb_segre_core.sv

//--- project.f
rtl/segre_pkg.sv
rtl/segre_decode.sv
rtl/segre_register_file.sv
rtl/segre_alu.sv
rtl/segre_ex_stage.sv
rtl/segre_core.sv
tb/segre_core_props.sv
tb/tb_segre_core.sv

//--- rtl/segre_alu.sv
`timescale 1ns/1ns

module segre_alu (
    input  segre_pkg::alu_opcode_e            alu_opcode_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   operand_a_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   operand_b_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   cmp_a_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   cmp_b_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   link_base_i,
    output logic [segre_pkg::WORD_SIZE-1:0]   result_o,
    output logic                              branch_taken_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   branch_target_o
);
import segre_pkg::*;

logic [WORD_SIZE-1:0] sum;
logic [4:0]           shamt;
logic                 lt_s;
logic                 lt_u;

assign sum   = operand_a_i + operand_b_i;
assign shamt = operand_b_i[4:0];
assign lt_s  = $signed(operand_a_i) < $signed(operand_b_i);
assign lt_u  = operand_a_i < operand_b_i;

always_comb begin
    result_o        = '0;               // M operations stay zero
    branch_taken_o  = 1'b0;
    branch_target_o = sum;

    case (alu_opcode_i)
        ALU_ADD:  result_o = sum;
        ALU_SUB:  result_o = operand_a_i - operand_b_i;
        ALU_SLL:  result_o = operand_a_i << shamt;
        ALU_SLT:  result_o = {{(WORD_SIZE-1){1'b0}}, lt_s};
        ALU_SLTU: result_o = {{(WORD_SIZE-1){1'b0}}, lt_u};
        ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
        ALU_SRL:  result_o = operand_a_i >> shamt;
        ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;
        ALU_OR:   result_o = operand_a_i | operand_b_i;
        ALU_AND:  result_o = operand_a_i & operand_b_i;
        ALU_JAL: begin
            result_o       = link_base_i + 32'd4;
            branch_taken_o = 1'b1;
        end
        ALU_JALR: begin
            result_o        = link_base_i + 32'd4;
            branch_taken_o  = 1'b1;
            branch_target_o = {sum[WORD_SIZE-1:1], 1'b0};
        end
        ALU_BEQ:  branch_taken_o = (cmp_a_i == cmp_b_i);
        ALU_BNE:  branch_taken_o = (cmp_a_i != cmp_b_i);
        ALU_BLT:  branch_taken_o = ($signed(cmp_a_i) < $signed(cmp_b_i));
        ALU_BGE:  branch_taken_o = ($signed(cmp_a_i) >= $signed(cmp_b_i));
        ALU_BLTU: branch_taken_o = (cmp_a_i < cmp_b_i);
        ALU_BGEU: branch_taken_o = (cmp_a_i >= cmp_b_i);
        default: ;
    endcase
end

endmodule

//--- rtl/segre_core.sv
`timescale 1ns/1ns

module segre_core (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              instr_valid_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   instr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   pc_i,
    output logic                              wb_valid_o,
    output logic [segre_pkg::REG_SIZE-1:0]    rd_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   result_o,
    output logic                              branch_taken_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   branch_target_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   mem_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   mem_wdata_o,
    output logic                              mem_rd_o,
    output logic                              mem_wr_o,
    output segre_pkg::memop_data_type_e       mem_type_o,
    output logic                              mem_sign_ext_o,
    output logic                              illegal_o
);
import segre_pkg::*;

logic [WORD_SIZE-1:0] imm_u, imm_i, imm_s, imm_j, imm_b;
logic [WORD_SIZE-1:0] rdata_a, rdata_b, operand_a, operand_b;
logic [WORD_SIZE-1:0] cmp_a, cmp_b, link_base, alu_result, alu_target;
logic [REG_SIZE-1:0]  raddr_a, raddr_b, waddr;
logic                 rf_we, wb_we, alu_taken;
logic                 memop_sign_ext, memop_rd, memop_wr, dec_illegal;
alu_opcode_e          alu_opcode;
alu_src_a_e           src_a_sel;
alu_src_b_e           src_b_sel;
alu_imm_a_e           a_imm_sel;
alu_imm_b_e           b_imm_sel;
br_src_a_e            br_a_sel;
br_src_b_e            br_b_sel;
memop_data_type_e     memop_type;
pipeline_e            pipeline;

segre_decode decode_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .instr_i(instr_i), .opcode_o(),
    .imm_u_type_o(imm_u), .imm_i_type_o(imm_i), .imm_s_type_o(imm_s),
    .imm_j_type_o(imm_j), .imm_b_type_o(imm_b), .alu_opcode_o(alu_opcode),
    .src_a_mux_sel_o(src_a_sel), .src_b_mux_sel_o(src_b_sel),
    .a_imm_mux_sel_o(a_imm_sel), .b_imm_mux_sel_o(b_imm_sel),
    .br_a_mux_sel_o(br_a_sel), .br_b_mux_sel_o(br_b_sel),
    .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .waddr_o(waddr), .rf_we_o(rf_we),
    .memop_type_o(memop_type), .memop_sign_ext_o(memop_sign_ext),
    .memop_rd_o(memop_rd), .memop_wr_o(memop_wr),
    .pipeline_o(pipeline), .illegal_o(dec_illegal)
);

segre_register_file register_file_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
    .we_i(wb_we), .waddr_i(rd_addr_o), .wdata_i(result_o),
    .rdata_a_o(rdata_a), .rdata_b_o(rdata_b)
);

segre_alu alu_i (
    .alu_opcode_i(alu_opcode), .operand_a_i(operand_a), .operand_b_i(operand_b),
    .cmp_a_i(cmp_a), .cmp_b_i(cmp_b), .link_base_i(link_base),
    .result_o(alu_result), .branch_taken_o(alu_taken), .branch_target_o(alu_target)
);

segre_ex_stage ex_stage_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .valid_i(instr_valid_i), .pc_i(pc_i),
    .rdata_a_i(rdata_a), .rdata_b_i(rdata_b), .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
    .waddr_i(waddr), .rf_we_i(rf_we),
    .imm_u_i(imm_u), .imm_i_i(imm_i), .imm_s_i(imm_s), .imm_j_i(imm_j), .imm_b_i(imm_b),
    .src_a_mux_sel_i(src_a_sel), .src_b_mux_sel_i(src_b_sel),
    .a_imm_mux_sel_i(a_imm_sel), .b_imm_mux_sel_i(b_imm_sel),
    .br_a_mux_sel_i(br_a_sel), .br_b_mux_sel_i(br_b_sel),
    .memop_type_i(memop_type), .memop_sign_ext_i(memop_sign_ext),
    .memop_rd_i(memop_rd), .memop_wr_i(memop_wr),
    .pipeline_i(pipeline), .illegal_i(dec_illegal),
    .result_i(alu_result), .branch_taken_i(alu_taken), .branch_target_i(alu_target),
    .operand_a_o(operand_a), .operand_b_o(operand_b),
    .cmp_a_o(cmp_a), .cmp_b_o(cmp_b), .link_base_o(link_base),
    .wb_valid_o(wb_valid_o), .wb_we_o(wb_we), .wb_addr_o(rd_addr_o), .wb_data_o(result_o),
    .branch_taken_o(branch_taken_o), .branch_target_o(branch_target_o),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
    .mem_rd_o(mem_rd_o), .mem_wr_o(mem_wr_o),
    .mem_type_o(mem_type_o), .mem_sign_ext_o(mem_sign_ext_o),
    .illegal_o(illegal_o)
);

endmodule

//--- rtl/segre_decode.sv
`timescale 1ns/1ns

module segre_decode (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   instr_i,
    output segre_pkg::opcode_e                opcode_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   imm_u_type_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   imm_i_type_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   imm_s_type_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   imm_j_type_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   imm_b_type_o,
    output segre_pkg::alu_opcode_e            alu_opcode_o,
    output segre_pkg::alu_src_a_e             src_a_mux_sel_o,
    output segre_pkg::alu_src_b_e             src_b_mux_sel_o,
    output segre_pkg::alu_imm_a_e             a_imm_mux_sel_o,
    output segre_pkg::alu_imm_b_e             b_imm_mux_sel_o,
    output segre_pkg::br_src_a_e              br_a_mux_sel_o,
    output segre_pkg::br_src_b_e              br_b_mux_sel_o,
    output logic [segre_pkg::REG_SIZE-1:0]    raddr_a_o,
    output logic [segre_pkg::REG_SIZE-1:0]    raddr_b_o,
    output logic [segre_pkg::REG_SIZE-1:0]    waddr_o,
    output logic                              rf_we_o,
    output segre_pkg::memop_data_type_e       memop_type_o,
    output logic                              memop_sign_ext_o,
    output logic                              memop_rd_o,
    output logic                              memop_wr_o,
    output segre_pkg::pipeline_e              pipeline_o,
    output logic                              illegal_o
);
import segre_pkg::*;

logic [2:0]       funct3;
logic [6:0]       funct7;
memop_data_type_e size_type;
logic             unknown_op;
logic             active_q;

assign funct3 = instr_i[FUNC3_LSB +: 3];
assign funct7 = instr_i[FUNC7_LSB +: 7];

assign imm_i_type_o = {{20{instr_i[31]}}, instr_i[31:20]};
assign imm_u_type_o = {instr_i[31:12], 12'b0};
assign imm_s_type_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
assign imm_j_type_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
assign imm_b_type_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

assign raddr_a_o = instr_i[RS1_LSB +: REG_SIZE];
assign raddr_b_o = instr_i[RS2_LSB +: REG_SIZE];
assign waddr_o   = instr_i[RD_LSB +: REG_SIZE];
assign opcode_o  = opcode_e'(instr_i[6:0]);

// Access size shared by loads and stores
assign size_type = (funct3[1:0] == 2'b00) ? BYTE :
                   (funct3[1:0] == 2'b01) ? HALF : WORD;

// Set on the first edge after reset release
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        active_q <= 1'b0;
    end else begin
        active_q <= 1'b1;
    end
end

assign illegal_o = unknown_op & active_q;

always_comb begin
    rf_we_o          = 1'b0;
    memop_rd_o       = 1'b0;
    memop_wr_o       = 1'b0;
    memop_sign_ext_o = 1'b0;
    memop_type_o     = WORD;
    unknown_op       = 1'b0;
    alu_opcode_o     = ALU_ADD;
    src_a_mux_sel_o  = ALU_A_REG;
    src_b_mux_sel_o  = ALU_B_IMM;
    a_imm_mux_sel_o  = IMM_A_ZERO;
    b_imm_mux_sel_o  = IMM_B_I;
    br_a_mux_sel_o   = BR_A_REG;
    br_b_mux_sel_o   = BR_B_REG;
    pipeline_o       = EX_PIPELINE;

    case (opcode_o)
        OPCODE_LUI: begin
            rf_we_o         = 1'b1;
            src_a_mux_sel_o = ALU_A_IMM;    // Zero plus U immediate
            b_imm_mux_sel_o = IMM_B_U;
        end
        OPCODE_AUIPC: begin
            rf_we_o         = 1'b1;
            src_a_mux_sel_o = ALU_A_PC;
            b_imm_mux_sel_o = IMM_B_U;
        end
        OPCODE_OP_IMM: begin
            rf_we_o = 1'b1;
            case (funct3)
                3'b001: alu_opcode_o = ALU_SLL;
                3'b010: alu_opcode_o = ALU_SLT;
                3'b011: alu_opcode_o = ALU_SLTU;
                3'b100: alu_opcode_o = ALU_XOR;
                3'b101: alu_opcode_o = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: alu_opcode_o = ALU_OR;
                3'b111: alu_opcode_o = ALU_AND;
                default: ;                  // ADDI
            endcase
        end
        OPCODE_OP: begin
            rf_we_o         = 1'b1;
            src_b_mux_sel_o = ALU_B_REG;
            if (funct7 == 7'b000_0001) begin
                pipeline_o = RVM_PIPELINE;
                case (funct3)
                    3'b000: alu_opcode_o = ALU_MUL;
                    3'b001: alu_opcode_o = ALU_MULH;
                    3'b010: alu_opcode_o = ALU_MULHSU;
                    3'b011: alu_opcode_o = ALU_MULHU;
                    3'b100: alu_opcode_o = ALU_DIV;
                    3'b101: alu_opcode_o = ALU_DIVU;
                    3'b110: alu_opcode_o = ALU_REM;
                    default: alu_opcode_o = ALU_REMU;
                endcase
            end else begin
                case ({funct7[5], funct3})
                    4'b1_000: alu_opcode_o = ALU_SUB;
                    4'b0_001: alu_opcode_o = ALU_SLL;
                    4'b0_010: alu_opcode_o = ALU_SLT;
                    4'b0_011: alu_opcode_o = ALU_SLTU;
                    4'b0_100: alu_opcode_o = ALU_XOR;
                    4'b0_101: alu_opcode_o = ALU_SRL;
                    4'b1_101: alu_opcode_o = ALU_SRA;
                    4'b0_110: alu_opcode_o = ALU_OR;
                    4'b0_111: alu_opcode_o = ALU_AND;
                    default: ;
                endcase
            end
        end
        OPCODE_LOAD: begin
            rf_we_o          = 1'b1;
            memop_rd_o       = 1'b1;
            memop_sign_ext_o = ~funct3[2];  // LBU and LHU zero-extend
            memop_type_o     = size_type;
            pipeline_o       = MEM_PIPELINE;
        end
        OPCODE_STORE: begin
            memop_wr_o      = 1'b1;
            memop_type_o    = size_type;
            b_imm_mux_sel_o = IMM_B_S;
            pipeline_o      = MEM_PIPELINE;
        end
        OPCODE_JAL: begin
            rf_we_o         = 1'b1;
            src_a_mux_sel_o = ALU_A_PC;
            b_imm_mux_sel_o = IMM_B_J;
            br_a_mux_sel_o  = BR_A_PC;      // Link from PC
            alu_opcode_o    = ALU_JAL;
        end
        OPCODE_JALR: begin
            rf_we_o        = 1'b1;
            br_a_mux_sel_o = BR_A_PC;
            alu_opcode_o   = ALU_JALR;
        end
        OPCODE_BRANCH: begin
            src_a_mux_sel_o = ALU_A_PC;
            b_imm_mux_sel_o = IMM_B_B;
            case (funct3)
                3'b001: alu_opcode_o = ALU_BNE;
                3'b100: alu_opcode_o = ALU_BLT;
                3'b101: alu_opcode_o = ALU_BGE;
                3'b110: alu_opcode_o = ALU_BLTU;
                3'b111: alu_opcode_o = ALU_BGEU;
                default: alu_opcode_o = ALU_BEQ;
            endcase
        end
        default: unknown_op = 1'b1;
    endcase
end

endmodule

//--- rtl/segre_ex_stage.sv
`timescale 1ns/1ns

module segre_ex_stage (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              valid_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   pc_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   rdata_a_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   rdata_b_i,
    input  logic [segre_pkg::REG_SIZE-1:0]    raddr_a_i,
    input  logic [segre_pkg::REG_SIZE-1:0]    raddr_b_i,
    input  logic [segre_pkg::REG_SIZE-1:0]    waddr_i,
    input  logic                              rf_we_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   imm_u_i, imm_i_i, imm_s_i, imm_j_i, imm_b_i,
    input  segre_pkg::alu_src_a_e             src_a_mux_sel_i,
    input  segre_pkg::alu_src_b_e             src_b_mux_sel_i,
    input  segre_pkg::alu_imm_a_e             a_imm_mux_sel_i,
    input  segre_pkg::alu_imm_b_e             b_imm_mux_sel_i,
    input  segre_pkg::br_src_a_e              br_a_mux_sel_i,
    input  segre_pkg::br_src_b_e              br_b_mux_sel_i,
    input  segre_pkg::memop_data_type_e       memop_type_i,
    input  logic                              memop_sign_ext_i,
    input  logic                              memop_rd_i,
    input  logic                              memop_wr_i,
    input  segre_pkg::pipeline_e              pipeline_i,
    input  logic                              illegal_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   result_i,
    input  logic                              branch_taken_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   branch_target_i,
    output logic [segre_pkg::WORD_SIZE-1:0]   operand_a_o, operand_b_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   cmp_a_o, cmp_b_o, link_base_o,
    output logic                              wb_valid_o,
    output logic                              wb_we_o,
    output logic [segre_pkg::REG_SIZE-1:0]    wb_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   wb_data_o,
    output logic                              branch_taken_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   branch_target_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   mem_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   mem_wdata_o,
    output logic                              mem_rd_o,
    output logic                              mem_wr_o,
    output segre_pkg::memop_data_type_e       mem_type_o,
    output logic                              mem_sign_ext_o,
    output logic                              illegal_o
);
import segre_pkg::*;

logic [WORD_SIZE-1:0] fwd_a;
logic [WORD_SIZE-1:0] fwd_b;
logic [WORD_SIZE-1:0] imm_a;
logic [WORD_SIZE-1:0] imm_b;

// Bypass from the writeback register except for x0
assign fwd_a = (wb_we_o && raddr_a_i != '0 && wb_addr_o == raddr_a_i) ? wb_data_o : rdata_a_i;
assign fwd_b = (wb_we_o && raddr_b_i != '0 && wb_addr_o == raddr_b_i) ? wb_data_o : rdata_b_i;

always_comb begin
    imm_a = '0;
    case (a_imm_mux_sel_i)
        IMM_A_ZERO: imm_a = '0;
        default: ;
    endcase

    case (b_imm_mux_sel_i)
        IMM_B_S: imm_b = imm_s_i;
        IMM_B_B: imm_b = imm_b_i;
        IMM_B_U: imm_b = imm_u_i;
        IMM_B_J: imm_b = imm_j_i;
        default: imm_b = imm_i_i;
    endcase

    case (src_a_mux_sel_i)
        ALU_A_PC:  operand_a_o = pc_i;
        ALU_A_IMM: operand_a_o = imm_a;
        default:   operand_a_o = fwd_a;
    endcase
end

assign operand_b_o = (src_b_mux_sel_i == ALU_B_IMM) ? imm_b : fwd_b;
assign cmp_a_o     = fwd_a;
assign cmp_b_o     = (br_b_mux_sel_i == BR_B_PC) ? pc_i : fwd_b;
assign link_base_o = (br_a_mux_sel_i == BR_A_PC) ? pc_i : fwd_a;

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        wb_valid_o     <= 1'b0;
        wb_we_o        <= 1'b0;
        branch_taken_o <= 1'b0;
        mem_rd_o       <= 1'b0;
        mem_wr_o       <= 1'b0;
        illegal_o      <= 1'b0;
    end else begin
        wb_valid_o     <= valid_i;
        wb_we_o        <= valid_i & rf_we_i & (pipeline_i == EX_PIPELINE);
        branch_taken_o <= valid_i & branch_taken_i;
        mem_rd_o       <= valid_i & memop_rd_i;
        mem_wr_o       <= valid_i & memop_wr_i;
        illegal_o      <= valid_i & illegal_i;
    end
end

always_ff @(posedge clk_i) begin
    wb_addr_o       <= waddr_i;
    wb_data_o       <= result_i;
    branch_target_o <= branch_target_i;
    mem_wdata_o     <= fwd_b;           // Store data after bypass
    mem_type_o      <= memop_type_i;
    mem_sign_ext_o  <= memop_sign_ext_i;
end

assign mem_addr_o = wb_data_o;          // Address comes out of the adder

endmodule

//--- rtl/segre_pkg.sv
package segre_pkg;

localparam int WORD_SIZE = 32;
localparam int REG_SIZE  = 5;
localparam int NUM_REGS  = 32;

// Instruction field positions
localparam int RS1_LSB   = 15;
localparam int RS2_LSB   = 20;
localparam int RD_LSB    = 7;
localparam int FUNC3_LSB = 12;
localparam int FUNC7_LSB = 25;

typedef enum logic [6:0] {
    OPCODE_LUI    = 7'b0110111,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_JAL    = 7'b1101111,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_BRANCH = 7'b1100011
} opcode_e;

typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_JAL,
    ALU_JALR,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU,
    ALU_MUL,      // M extension decoded only
    ALU_MULH,
    ALU_MULHSU,
    ALU_MULHU,
    ALU_DIV,
    ALU_DIVU,
    ALU_REM,
    ALU_REMU
} alu_opcode_e;

typedef enum logic [1:0] {
    ALU_A_REG,
    ALU_A_PC,
    ALU_A_IMM
} alu_src_a_e;

typedef enum logic {
    ALU_B_REG,
    ALU_B_IMM
} alu_src_b_e;

typedef enum logic {
    IMM_A_ZERO
} alu_imm_a_e;

typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J
} alu_imm_b_e;

typedef enum logic { BR_A_REG, BR_A_PC } br_src_a_e;
typedef enum logic { BR_B_REG, BR_B_PC } br_src_b_e;

typedef enum logic [1:0] { BYTE, HALF, WORD } memop_data_type_e;

typedef enum logic [1:0] {
    EX_PIPELINE,
    MEM_PIPELINE,
    RVM_PIPELINE
} pipeline_e;

endpackage

//--- rtl/segre_register_file.sv
`timescale 1ns/1ns

module segre_register_file (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [segre_pkg::REG_SIZE-1:0]    raddr_a_i,
    input  logic [segre_pkg::REG_SIZE-1:0]    raddr_b_i,
    input  logic                              we_i,
    input  logic [segre_pkg::REG_SIZE-1:0]    waddr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   wdata_i,
    output logic [segre_pkg::WORD_SIZE-1:0]   rdata_a_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   rdata_b_o
);
import segre_pkg::*;

logic [WORD_SIZE-1:0] regs_q [1:NUM_REGS-1];   // x0 not stored

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
        end
    end else if (we_i && waddr_i != '0) begin
        regs_q[waddr_i] <= wdata_i;
    end
end

assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- tb/segre_core_props.sv
`timescale 1ns/1ns

module segre_core_props (
    input logic                              clk_i,
    input logic                              arst_n_i,
    input logic                              instr_valid_i,
    input logic                              wb_valid_i,
    input logic                              branch_taken_i,
    input logic [segre_pkg::WORD_SIZE-1:0]   branch_target_i,
    input logic                              mem_rd_i,
    input logic                              mem_wr_i,
    input logic                              illegal_i
);

int unsigned fail_count = 0;

no_rd_wr_overlap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(mem_rd_i && mem_wr_i))
    else begin $error("mem_rd_o and mem_wr_o high together"); fail_count++; end

strobes_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> !(wb_valid_i || mem_rd_i || mem_wr_i || branch_taken_i || illegal_i))
    else begin $error("strobe active during reset"); fail_count++; end

target_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    branch_taken_i |-> !branch_target_i[0])
    else begin $error("taken branch target has bit 0 set"); fail_count++; end

valid_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_i == $past(instr_valid_i))
    else begin $error("wb_valid_o does not follow instr_valid_i"); fail_count++; end

endmodule

bind segre_core segre_core_props props_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .instr_valid_i(instr_valid_i),
    .wb_valid_i(wb_valid_o), .branch_taken_i(branch_taken_o),
    .branch_target_i(branch_target_o), .mem_rd_i(mem_rd_o), .mem_wr_i(mem_wr_o),
    .illegal_i(illegal_o)
);

//--- tb/tb_segre_core.sv
`timescale 1ns/1ns

module tb_segre_core;
import segre_pkg::*;

localparam int TIMEOUT_CYCLES = 600;    // 8 reset + ~50 directed + 400 random + idle gaps

logic                 clk_i;
logic                 arst_n_i;
logic                 instr_valid_i;
logic [WORD_SIZE-1:0] instr_i;
logic [WORD_SIZE-1:0] pc_i;
logic                 wb_valid_o, branch_taken_o, mem_rd_o, mem_wr_o, mem_sign_ext_o, illegal_o;
logic [REG_SIZE-1:0]  rd_addr_o;
logic [WORD_SIZE-1:0] result_o, branch_target_o, mem_addr_o, mem_wdata_o;
memop_data_type_e     mem_type_o;

logic [WORD_SIZE-1:0] regs [0:NUM_REGS-1];  // Architectural register model
int unsigned          errors;
int unsigned          cycle_count;
logic                 pend, exp_we, exp_taken, exp_mrd, exp_mwr, exp_sext, exp_ill;
logic                 chk_res, chk_tgt, chk_mem;
logic [REG_SIZE-1:0]  exp_rd;
logic [WORD_SIZE-1:0] exp_res, exp_tgt, exp_wdata;
memop_data_type_e     exp_type;

logic [WORD_SIZE-1:0] directed [0:18] = '{
    32'hffb0_0093, 32'h0010_8133, 32'h4011_01b3,    // addi x1,-5; add x2,x1,x1; sub x3,x2,x1
    32'h0070_8013, 32'h0000_0233,                   // addi x0,x1,7; add x4,x0,x0
    32'h0220_81b3, 32'h0001_8333,                   // mul x3 then read x3
    32'h0080_a383, 32'h0003_8433,                   // lw x7 then read x7
    32'hfe20_8e23, 32'h0010_8863, 32'h0030_8567,    // sb; beq taken; jalr x10,3(x1)
    32'h0080_05ef, 32'h1234_5637, 32'h0000_1697,    // jal; lui; auipc
    32'h0000_007f, 32'h0000_0000,                   // Unknown opcodes
    32'h0021_5703, 32'h0031_2023                    // lhu; sw
};

segre_core segre_core_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .instr_valid_i(instr_valid_i),
    .instr_i(instr_i), .pc_i(pc_i), .wb_valid_o(wb_valid_o), .rd_addr_o(rd_addr_o),
    .result_o(result_o), .branch_taken_o(branch_taken_o), .branch_target_o(branch_target_o),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_rd_o(mem_rd_o),
    .mem_wr_o(mem_wr_o), .mem_type_o(mem_type_o), .mem_sign_ext_o(mem_sign_ext_o),
    .illegal_o(illegal_o)
);

initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
end

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'd0: return alt ? x - y : x + y;
        3'd1: return x << y[4:0];
        3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'd3: return (x < y) ? 32'd1 : 32'd0;
        3'd4: return x ^ y;
        3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6: return x | y;
        default: return x & y;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                    input logic [31:0] y);
    case (f3)
        3'd0: return x == y;
        3'd1: return x != y;
        3'd4: return $signed(x) < $signed(y);
        3'd5: return !($signed(x) < $signed(y));
        3'd6: return x < y;
        default: return !(x < y);
    endcase
endfunction

// Random legal instruction with registers limited to x0..x7 for frequent hazards
function automatic logic [31:0] rand_instr();
    logic [31:0] w;
    logic [2:0]  f3;
    int unsigned kind;
    w               = $urandom;
    w[RS1_LSB +: 5] = 5'($urandom % 8);
    w[RS2_LSB +: 5] = 5'($urandom % 8);
    w[RD_LSB +: 5]  = 5'($urandom % 8);
    f3              = w[FUNC3_LSB +: 3];
    kind            = $urandom % 10;
    case (kind)
        0: w[6:0] = OPCODE_LUI;
        1: w[6:0] = OPCODE_AUIPC;
        2, 3: begin
            w[6:0] = OPCODE_OP_IMM;
            if (f3 == 3'd1) w[31:25] = 7'b0;
            if (f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
        end
        4, 5: begin
            w[6:0]   = OPCODE_OP;
            w[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, w[30], 5'b0} : 7'b0;
        end
        6: begin
            w[6:0] = OPCODE_LOAD;
            if (f3 == 3'd3 || f3[2:1] == 2'b11) w[14:12] = 3'b010;
        end
        7: begin
            w[6:0]   = OPCODE_STORE;
            w[14:12] = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
        end
        8: begin
            w[6:0] = OPCODE_BRANCH;
            if (f3[2:1] == 2'b01) w[14] = 1'b1;
        end
        default: begin
            w[6:0] = ($urandom % 2) ? OPCODE_JAL : OPCODE_JALR;
            if (w[6:0] == OPCODE_JALR) w[14:12] = 3'b000;
        end
    endcase
    return w;
endfunction

task automatic predict(input logic [31:0] ins, input logic [31:0] pc);
    logic [2:0]  f3;
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
    f3        = ins[FUNC3_LSB +: 3];
    a         = regs[ins[RS1_LSB +: REG_SIZE]];
    b         = regs[ins[RS2_LSB +: REG_SIZE]];
    imm_i     = 32'($signed(ins) >>> 20);
    imm_s     = {imm_i[31:5], ins[11:7]};
    imm_b     = {imm_s[31:12], ins[7], imm_s[10:1], 1'b0};
    imm_u     = ins & 32'hffff_f000;
    imm_j     = {imm_i[31:20], ins[19:12], imm_i[0], imm_i[10:1], 1'b0};
    exp_rd    = ins[RD_LSB +: REG_SIZE];
    exp_type  = memop_data_type_e'(f3[1:0]);
    exp_wdata = b;
    {exp_we, exp_taken, exp_mrd, exp_mwr, exp_sext, exp_ill} = '0;
    {chk_res, chk_tgt, chk_mem} = '0;
    exp_res   = '0;
    exp_tgt   = '0;
    case (ins[6:0])
        OPCODE_LUI:    {exp_res, exp_we, chk_res} = {imm_u, 2'b11};
        OPCODE_AUIPC:  {exp_res, exp_we, chk_res} = {pc + imm_u, 2'b11};
        OPCODE_OP_IMM: {exp_res, exp_we, chk_res} =
            {alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i), 2'b11};
        OPCODE_OP: begin
            if (ins[25] == 1'b0) begin                  // M ops write nothing
                {exp_res, exp_we, chk_res} = {alu_ref(f3, ins[30], a, b), 2'b11};
            end
        end
        OPCODE_LOAD:  {exp_res, exp_mrd, exp_sext, chk_res, chk_mem} =
            {a + imm_i, 1'b1, ~f3[2], 2'b11};
        OPCODE_STORE: {exp_res, exp_mwr, chk_res, chk_mem} = {a + imm_s, 3'b111};
        OPCODE_JAL:   {exp_res, exp_we, chk_res, exp_taken, chk_tgt, exp_tgt} =
            {pc + 32'd4, 4'b1111, pc + imm_j};
        OPCODE_JALR:  {exp_res, exp_we, chk_res, exp_taken, chk_tgt, exp_tgt} =
            {pc + 32'd4, 4'b1111, (a + imm_i) & ~32'd1};
        OPCODE_BRANCH: {exp_taken, chk_tgt, exp_tgt} = {branch_ref(f3, a, b), 1'b1, pc + imm_b};
        default: exp_ill = 1'b1;
    endcase
endtask

task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    errors++;
endtask

task automatic check_outputs();
    assert (wb_valid_o == pend) else mismatch("wb_valid_o", wb_valid_o, pend);
    if (!pend) begin
        assert (!(mem_rd_o | mem_wr_o | branch_taken_o | illegal_o))
            else mismatch("idle strobes", {mem_rd_o, mem_wr_o, branch_taken_o, illegal_o}, 0);
        return;
    end
    assert (rd_addr_o == exp_rd) else mismatch("rd_addr_o", rd_addr_o, exp_rd);
    assert (illegal_o == exp_ill) else mismatch("illegal_o", illegal_o, exp_ill);
    assert (mem_rd_o == exp_mrd) else mismatch("mem_rd_o", mem_rd_o, exp_mrd);
    assert (mem_wr_o == exp_mwr) else mismatch("mem_wr_o", mem_wr_o, exp_mwr);
    assert (branch_taken_o == exp_taken)
        else mismatch("branch_taken_o", branch_taken_o, exp_taken);
    if (chk_res) assert (result_o == exp_res) else mismatch("result_o", result_o, exp_res);
    if (chk_tgt) assert (branch_target_o == exp_tgt)
        else mismatch("branch_target_o", branch_target_o, exp_tgt);
    if (chk_mem) begin
        assert (mem_addr_o == exp_res) else mismatch("mem_addr_o", mem_addr_o, exp_res);
        assert (mem_type_o == exp_type) else mismatch("mem_type_o", mem_type_o, exp_type);
        assert (mem_sign_ext_o == exp_sext)
            else mismatch("mem_sign_ext_o", mem_sign_ext_o, exp_sext);
        if (exp_mwr) assert (mem_wdata_o == exp_wdata)
            else mismatch("mem_wdata_o", mem_wdata_o, exp_wdata);
    end
    if (exp_we && exp_rd != '0) regs[exp_rd] = exp_res;
endtask

// Check the instruction in writeback and then issue the next
task automatic step(input logic valid, input logic [31:0] ins, input logic [31:0] pc);
    @(posedge clk_i);
    #10;
    check_outputs();
    instr_valid_i = valid;
    instr_i       = ins;
    pc_i          = pc;
    pend          = valid;
    if (valid) predict(ins, pc);
endtask

initial begin
    logic [31:0] pc;
    void'($urandom(32'hd22c_d376));
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = 32'h0000_0013;
    pc_i          = '0;
    pend          = 1'b0;
    errors        = 0;
    for (int r = 0; r < NUM_REGS; r++) regs[r] = '0;
    repeat (8) @(posedge clk_i);
    #10;
    arst_n_i = 1'b1;
    step(1'b0, 32'h0000_0013, '0);
    pc = 32'h0000_1000;
    for (int r = 1; r < NUM_REGS; r++) begin
        step(1'b1, {7'b0, 5'd0, 5'(r), 3'b000, 5'd0, OPCODE_OP}, pc);   // add x0, xr, x0
        pc += 4;
    end
    foreach (directed[i]) begin
        step(1'b1, directed[i], pc);
        pc += 4;
    end
    for (int n = 0; n < 400; n++) begin
        if ($urandom % 10 == 0) step(1'b0, 32'h0000_0013, '0);
        step(1'b1, rand_instr(), $urandom & 32'hffff_fffc);
    end
    step(1'b0, 32'h0000_0013, '0);
    $display("Errors: %0d value mismatches, %0d assertion failures",
             errors, segre_core_i.props_i.fail_count);
    if (errors == 0 && segre_core_i.props_i.fail_count == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
        @(posedge clk_i);
        cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
end

endmodule
